/* src/stream_demux_settings.svh */
// widths fixed at build time; both length fields sit in the low header bits and MAX_POS_W must cover the wider one
`ifndef STREAM_DEMUX_SETTINGS_SVH
`define STREAM_DEMUX_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// stream geometry
//////////////////////////////////////////////////////////////////////

// one transfer on every stream
`define STREAM_W            128
// 2-bit base encoding
`define BASE_W              2
// STREAM_W / BASE_W
`define BASES_PER_TX        64
`define LOG_BASES_PER_TX    6

//////////////////////////////////////////////////////////////////////
// sequence lengths
//////////////////////////////////////////////////////////////////////

`define MAX_STREAM1_LEN     100
`define MAX_STREAM2_LEN     100
// ceil(log2) of the maximum lengths
`define STREAM1_POS_W       7
`define STREAM2_POS_W       7
`define MAX_POS_W           7

// register block
`define REG_BASE_ADDR       32'h0000_0000
`define REG_VERSION         32'h0000_0001

`endif

/* src/stream_demux_pkg.sv */
// types only; all widths come from the settings header, which must be compiled in with this package
`include "stream_demux_settings.svh"

package stream_demux_pkg;

    //////////////////////////////////////////////////////////////////////
    // stream payload
    //////////////////////////////////////////////////////////////////////

    // one transfer, header or 64 bases
    typedef logic [`STREAM_W-1:0] stream_word_t;

    // length in bases, or transfers left in a sequence
    typedef logic [`MAX_POS_W-1:0] seq_length_t;

    //////////////////////////////////////////////////////////////////////
    // sequencer
    //////////////////////////////////////////////////////////////////////

    // header state, then data state, per stream
    typedef enum logic [1:0] {
        INFO_1 = 2'd0,
        DATA_1 = 2'd1,
        INFO_2 = 2'd2,
        DATA_2 = 2'd3
    } demux_state_e;

    //////////////////////////////////////////////////////////////////////
    // statistics and register port
    //////////////////////////////////////////////////////////////////////

    // free-running transfer counts, wrap at 2^32
    typedef struct packed {
        logic [31:0] in_count;
        logic [31:0] s1_count;
        logic [31:0] s2_count;
    } xfer_counts_t;

    // plain strobes, no handshake
    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [31:0] addr;
    } reg_req_t;

    // offsets from REG_BASE_ADDR
    typedef enum logic [31:0] {
        REG_VERSION_ADDR = 32'h0000_0000,
        REG_IN_COUNT     = 32'h0000_0010,
        REG_S1_COUNT     = 32'h0000_0020,
        REG_S2_COUNT     = 32'h0000_0030
    } reg_addr_e;

endpackage

/* src/demux_sequencer.sv */
// assumes strict stream 1 / stream 2 alternation and a header length no larger than its field allows
`include "stream_demux_settings.svh"

module demux_sequencer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  stream_demux_pkg::stream_word_t in_data,
    input  logic                          buf_free,
    output logic                          in_ready,
    output logic                          to_stream2
);
    import stream_demux_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // signals
    //////////////////////////////////////////////////////////////////////

    demux_state_e          state;
    demux_state_e          next_state;

    // transfers still to take for the current sequence
    seq_length_t           tx_remaining;

    // header length field and derived transfer count
    seq_length_t           hdr_len;
    logic [`MAX_POS_W:0]   len_round;
    seq_length_t           tx_total;

    logic                  in_info;
    logic                  in_data_state;
    logic                  load_info;
    logic                  in_take;
    logic                  last_tx;

    //////////////////////////////////////////////////////////////////////
    // state decode
    //////////////////////////////////////////////////////////////////////

    assign in_info       = (state == INFO_1) || (state == INFO_2);
    assign in_data_state = (state == DATA_1) || (state == DATA_2);

    // second half of each pair goes to stream 2
    assign to_stream2 = (state == INFO_2) || (state == DATA_2);

    // only take words when the shared buffer can hold them
    assign in_ready = in_data_state && buf_free;
    assign in_take  = in_valid && in_ready;

    // header is peeked in INFO, not consumed
    assign load_info = in_info && in_valid;

    assign last_tx = (tx_remaining == seq_length_t'(1));

    //////////////////////////////////////////////////////////////////////
    // header length to transfer count
    //////////////////////////////////////////////////////////////////////

    // pick the field width of the stream being served
    always_comb begin
        if (to_stream2) begin
            hdr_len = seq_length_t'(in_data[`STREAM2_POS_W-1:0]);
        end else begin
            hdr_len = seq_length_t'(in_data[`STREAM1_POS_W-1:0]);
        end
    end

    // one extra bit so the round-up add cannot overflow
    assign len_round = {1'b0, hdr_len} + ((`MAX_POS_W) + 1)'(`BASES_PER_TX - 1);

    // header transfer plus ceil(len / 64) base transfers
    assign tx_total = seq_length_t'(1) + seq_length_t'(len_round >> `LOG_BASES_PER_TX);

    //////////////////////////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            INFO_1: begin
                if (in_valid) begin
                    next_state = DATA_1;
                end
            end
            DATA_1: begin
                // last word of the stream 1 sequence
                if (in_take && last_tx) begin
                    next_state = INFO_2;
                end
            end
            INFO_2: begin
                if (in_valid) begin
                    next_state = DATA_2;
                end
            end
            DATA_2: begin
                if (in_take && last_tx) begin
                    next_state = INFO_1;
                end
            end
            default: begin
                next_state = INFO_1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= INFO_1;
        end else begin
            state <= next_state;
        end
    end

    // loaded in INFO, counts down once per accepted word
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_remaining <= '0;
        end else if (load_info) begin
            tx_remaining <= tx_total;
        end else if (in_take) begin
            tx_remaining <= tx_remaining - seq_length_t'(1);
        end
    end

endmodule

/* src/demux_output_buffer.sv */
// single shared word of storage, so at most one output valid is high and out_data is undefined until the first transfer
module demux_output_buffer (
    input  logic                           clk,
    input  logic                           rst,
    input  stream_demux_pkg::stream_word_t in_data,
    input  logic                           in_ready,
    input  logic                           in_valid,
    input  logic                           to_stream2,
    input  logic                           s1_ready,
    input  logic                           s2_ready,
    output logic                           s1_valid,
    output logic                           s2_valid,
    output stream_demux_pkg::stream_word_t out_data,
    output logic                           buf_free
);

    //////////////////////////////////////////////////////////////////////
    // handshakes
    //////////////////////////////////////////////////////////////////////

    logic in_take;
    logic s1_take;
    logic s2_take;
    logic out_take;

    assign in_take  = in_valid && in_ready;
    assign s1_take  = s1_valid && s1_ready;
    assign s2_take  = s2_valid && s2_ready;
    assign out_take = s1_take || s2_take;

    // empty, or the held word leaves this cycle
    // lets a sequence stream at one word per clock
    assign buf_free = !(s1_valid || s2_valid) || out_take;

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    // payload holds while the outputs stall
    always_ff @(posedge clk) begin
        if (in_take) begin
            out_data <= in_data;
        end
    end

    // load wins over drain when both happen in one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (in_take) begin
            s1_valid <= !to_stream2;
            s2_valid <= to_stream2;
        end else if (out_take) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end
    end

endmodule

/* src/demux_stat_regs.sv */
// read-only register block on clk; writes are ignored and counters wrap silently at 2^32
`include "stream_demux_settings.svh"

module demux_stat_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  logic                       in_ready,
    input  logic                       s1_valid,
    input  logic                       s1_ready,
    input  logic                       s2_valid,
    input  logic                       s2_ready,
    input  stream_demux_pkg::reg_req_t req,
    output logic [31:0]                rd_data
);
    import stream_demux_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // transfer counters
    //////////////////////////////////////////////////////////////////////

    xfer_counts_t counts;

    logic in_take;
    logic s1_take;
    logic s2_take;

    assign in_take = in_valid && in_ready;
    assign s1_take = s1_valid && s1_ready;
    assign s2_take = s2_valid && s2_ready;

    // one counter per stream, independent enables
    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '0;
        end else begin
            if (in_take) begin
                counts.in_count <= counts.in_count + 32'd1;
            end
            if (s1_take) begin
                counts.s1_count <= counts.s1_count + 32'd1;
            end
            if (s2_take) begin
                counts.s2_count <= counts.s2_count + 32'd1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // register read port
    //////////////////////////////////////////////////////////////////////

    // offset inside the block, unmapped values fall to default
    reg_addr_e rd_offset;

    assign rd_offset = reg_addr_e'(req.addr - `REG_BASE_ADDR);

    // data valid one cycle after the strobe
    // counter value is the one seen in the strobe cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else if (req.rd && !req.wr) begin
            case (rd_offset)
                REG_VERSION_ADDR: rd_data <= `REG_VERSION;
                REG_IN_COUNT:     rd_data <= counts.in_count;
                REG_S1_COUNT:     rd_data <= counts.s1_count;
                REG_S2_COUNT:     rd_data <= counts.s2_count;
                default:          rd_data <= '0;
            endcase
        end else begin
            // write, idle or read with write both high
            rd_data <= '0;
        end
    end

endmodule

/* src/stream_demux.sv */
// one input stream split into two by alternating sequences; outputs share out_data and never overlap
module stream_demux (
    input  logic                           clk,
    input  logic                           rst,

    // input stream, header then bases per sequence
    input  logic                           in_valid,
    input  stream_demux_pkg::stream_word_t in_data,
    output logic                           in_ready,

    // output streams, one shared data bus
    output logic                           s1_valid,
    input  logic                           s1_ready,
    output logic                           s2_valid,
    input  logic                           s2_ready,
    output stream_demux_pkg::stream_word_t out_data,

    // register port
    input  stream_demux_pkg::reg_req_t     req,
    output logic [31:0]                    rd_data
);

    //////////////////////////////////////////////////////////////////////
    // internal links
    //////////////////////////////////////////////////////////////////////

    // buffer can accept a word this cycle
    logic buf_free;
    // current sequence belongs to stream 2
    logic to_stream2;

    // header parse and input flow control
    demux_sequencer sequencer_inst (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .buf_free   (buf_free),
        .in_ready   (in_ready),
        .to_stream2 (to_stream2)
    );

    // shared one-word output stage
    demux_output_buffer output_buffer_inst (
        .clk        (clk),
        .rst        (rst),
        .in_data    (in_data),
        .in_ready   (in_ready),
        .in_valid   (in_valid),
        .to_stream2 (to_stream2),
        .s1_ready   (s1_ready),
        .s2_ready   (s2_ready),
        .s1_valid   (s1_valid),
        .s2_valid   (s2_valid),
        .out_data   (out_data),
        .buf_free   (buf_free)
    );

    // counts taken from the top-level handshakes
    demux_stat_regs stat_regs_inst (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .s1_valid (s1_valid),
        .s1_ready (s1_ready),
        .s2_valid (s2_valid),
        .s2_ready (s2_ready),
        .req      (req),
        .rd_data  (rd_data)
    );

endmodule

/* dv/stream_demux_tb.sv */
// random traffic with a fixed seed; needs a simulator with timing support and ends within DRAIN_TIMEOUT cycles
`include "stream_demux_settings.svh"

module stream_demux_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import stream_demux_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // constants and signals
    //////////////////////////////////////////////////////////////////////

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 16;
    localparam int NUM_PAIRS     = 40;
    localparam int DRAIN_TIMEOUT = 20000;

    integer       seed;

    logic         clk = 1'b0;
    logic         rst = 1'b1;
    logic         in_valid = 1'b0;
    stream_word_t in_data = '0;
    logic         in_ready;
    logic         s1_valid;
    logic         s1_ready = 1'b0;
    logic         s2_valid;
    logic         s2_ready = 1'b0;
    stream_word_t out_data;
    reg_req_t     req = '0;
    logic [31:0]  rd_data;

    // words in input order, and what each output should deliver
    stream_word_t stim_q[$];
    stream_word_t exp_q1[$];
    stream_word_t exp_q2[$];
    int           in_pos = 0;

    // model counts and counts seen at the ports
    logic [31:0]  exp_in = '0;
    logic [31:0]  exp_s1 = '0;
    logic [31:0]  exp_s2 = '0;
    logic [31:0]  seen_in = '0;
    logic [31:0]  seen_s1 = '0;
    logic [31:0]  seen_s2 = '0;

    // values returned by the register port
    logic [31:0]  last_rd = '0;
    logic [31:0]  rd_in_count = '0;
    logic [31:0]  rd_s1_count = '0;
    logic [31:0]  rd_s2_count = '0;

    // stall state from the previous edge
    logic         s1_stalled = 1'b0;
    logic         s2_stalled = 1'b0;
    stream_word_t held_word = '0;
    stream_word_t exp_word;

    always #(CLK_PERIOD / 2) clk = ~clk;

    stream_demux stream_demux_inst (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_ready (in_ready),
        .s1_valid (s1_valid),
        .s1_ready (s1_ready),
        .s2_valid (s2_valid),
        .s2_ready (s2_ready),
        .out_data (out_data),
        .req      (req),
        .rd_data  (rd_data)
    );

    //////////////////////////////////////////////////////////////////////
    // failure reporting and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic fail_with(input string what);
        $display("%s", what);
        abort_run();
    endtask

    task automatic check_word(input string name, input stream_word_t expected,
                              input stream_word_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s expected %b actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic stream_word_t random_word();
        random_word = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // edge lengths first, then random 0 to 100
    function automatic int unsigned pick_length(input int k);
        case (k)
            0: pick_length = 0;
            1: pick_length = 64;
            2: pick_length = 65;
            3: pick_length = 100;
            4: pick_length = 1;
            5: pick_length = 63;
            default: pick_length = $unsigned($random(seed)) % 101;
        endcase
    endfunction

    // header plus ceil(len / 64) base words, streams alternate 1, 2, 1, ...
    task automatic build_traffic();
        int unsigned  len;
        int unsigned  n_tx;
        stream_word_t word;
        for (int k = 0; k < 2 * NUM_PAIRS; k++) begin
            len = pick_length(k);
            n_tx = 1 + (len + `BASES_PER_TX - 1) / `BASES_PER_TX;
            for (int unsigned t = 0; t < n_tx; t++) begin
                word = random_word();
                // low bits of the header carry the length
                if (t == 0) begin
                    word[`MAX_POS_W-1:0] = len[`MAX_POS_W-1:0];
                end
                stim_q.push_back(word);
                if (k % 2 == 0) begin
                    exp_q1.push_back(word);
                end else begin
                    exp_q2.push_back(word);
                end
            end
            exp_in = exp_in + n_tx;
            if (k % 2 == 0) begin
                exp_s1 = exp_s1 + n_tx;
            end else begin
                exp_s2 = exp_s2 + n_tx;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus and output monitor
    //////////////////////////////////////////////////////////////////////

    // input word holds until taken, gaps only between words
    always @(posedge clk) begin
        if (rst) begin
            in_valid <= 1'b0;
            s1_ready <= 1'b0;
            s2_ready <= 1'b0;
        end else begin
            if (!in_valid || in_ready) begin
                if (in_pos < stim_q.size() && ($unsigned($random(seed)) % 4) != 0) begin
                    in_valid <= 1'b1;
                    in_data  <= stim_q[in_pos];
                    in_pos = in_pos + 1;
                end else begin
                    in_valid <= 1'b0;
                end
            end
            // each ready low about a third of the time
            s1_ready <= ($unsigned($random(seed)) % 3) != 0;
            s2_ready <= ($unsigned($random(seed)) % 3) != 0;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            s1_stalled = 1'b0;
            s2_stalled = 1'b0;
        end else begin
            if (s1_valid && s2_valid) begin
                fail_with("s1_valid and s2_valid are high in the same cycle");
            end
            if (s1_stalled) begin
                check_flag("s1_valid held under back-pressure", 1'b1, s1_valid);
                check_word("out_data held while output 1 stalls", held_word, out_data);
            end
            if (s2_stalled) begin
                check_flag("s2_valid held under back-pressure", 1'b1, s2_valid);
                check_word("out_data held while output 2 stalls", held_word, out_data);
            end
            if (in_valid && in_ready) begin
                seen_in = seen_in + 32'd1;
            end
            if (s1_valid && s1_ready) begin
                if (exp_q1.size() == 0) begin
                    fail_with("output 1 delivered a word when none was expected");
                end else begin
                    exp_word = exp_q1.pop_front();
                    check_word("stream 1 word", exp_word, out_data);
                    seen_s1 = seen_s1 + 32'd1;
                end
            end
            if (s2_valid && s2_ready) begin
                if (exp_q2.size() == 0) begin
                    fail_with("output 2 delivered a word when none was expected");
                end else begin
                    exp_word = exp_q2.pop_front();
                    check_word("stream 2 word", exp_word, out_data);
                    seen_s2 = seen_s2 + 32'd1;
                end
            end
            s1_stalled = s1_valid && !s1_ready;
            s2_stalled = s2_valid && !s2_ready;
            held_word = out_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sequence helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_outputs_idle(input string when);
        check_flag({when, " in_ready"}, 1'b0, in_ready);
        check_flag({when, " s1_valid"}, 1'b0, s1_valid);
        check_flag({when, " s2_valid"}, 1'b0, s2_valid);
        check_count({when, " rd_data"}, 32'd0, rd_data);
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while ((exp_q1.size() != 0 || exp_q2.size() != 0) && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        if (exp_q1.size() != 0 || exp_q2.size() != 0) begin
            fail_with($sformatf("timeout: %0d words for output 1 and %0d for output 2 never came",
                                exp_q1.size(), exp_q2.size()));
        end
    endtask

    // drives this cycle's request, then checks the previous request's read data
    task automatic reg_step(input logic do_rd, input logic do_wr, input logic [31:0] addr,
                            input string name, input logic [31:0] expected);
        reg_req_t next_req;
        next_req.rd = do_rd;
        next_req.wr = do_wr;
        next_req.addr = addr;
        @(posedge clk);
        req <= next_req;
        @(negedge clk);
        check_count(name, expected, rd_data);
        last_rd = rd_data;
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed = 32'h9474e27c;
        build_traffic();

        for (int i = 0; i < RESET_CYCLES - 1; i++) begin
            @(negedge clk);
            check_outputs_idle("during reset");
        end
        @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_outputs_idle("first cycle after reset");

        wait_for_drain();

        check_count("input transfers seen", exp_in, seen_in);
        check_count("output 1 transfers seen", exp_s1, seen_s1);
        check_count("output 2 transfers seen", exp_s2, seen_s2);

        // each step checks the result of the one before
        reg_step(1'b1, 1'b0, `REG_BASE_ADDR + REG_VERSION_ADDR, "idle before reads", 32'd0);
        reg_step(1'b1, 1'b0, `REG_BASE_ADDR + REG_IN_COUNT, "version read", `REG_VERSION);
        reg_step(1'b1, 1'b0, `REG_BASE_ADDR + REG_S1_COUNT, "input count read", exp_in);
        rd_in_count = last_rd;
        reg_step(1'b1, 1'b0, `REG_BASE_ADDR + REG_S2_COUNT, "stream 1 count read", exp_s1);
        rd_s1_count = last_rd;
        reg_step(1'b0, 1'b1, `REG_BASE_ADDR + REG_VERSION_ADDR, "stream 2 count read", exp_s2);
        rd_s2_count = last_rd;
        check_count("input count register equals both output count registers",
                    rd_s1_count + rd_s2_count, rd_in_count);
        reg_step(1'b1, 1'b0, `REG_BASE_ADDR + REG_VERSION_ADDR, "write returns zero", 32'd0);
        reg_step(1'b1, 1'b1, `REG_BASE_ADDR + REG_VERSION_ADDR, "version reread", `REG_VERSION);
        reg_step(1'b1, 1'b0, `REG_BASE_ADDR + REG_VERSION_ADDR, "read with write", 32'd0);
        reg_step(1'b1, 1'b0, `REG_BASE_ADDR + 32'h14, "version before unmapped", `REG_VERSION);
        reg_step(1'b1, 1'b0, `REG_BASE_ADDR + REG_VERSION_ADDR, "unmapped read", 32'd0);
        reg_step(1'b0, 1'b0, 32'd0, "version before idle", `REG_VERSION);
        reg_step(1'b0, 1'b0, 32'd0, "idle cycle", 32'd0);

        $display("TEST PASS");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+src
src/stream_demux_pkg.sv
src/demux_sequencer.sv
src/demux_output_buffer.sv
src/demux_stat_regs.sv
src/stream_demux.sv
dv/stream_demux_tb.sv

/* Makefile */
# Verilator build and run for the stream demultiplexer testbench

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= stream_demux_tb
LINT_TOP  ?= stream_demux
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

# the run passes only when the pass line appears in the output
run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)
